/* design/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 16

// Word and address sizes
`define CACHE_DATA_W 32
`define CACHE_ADDR_W 16

// Transaction id carried by core requests
`define CACHE_TID_W 4

// Derived widths
`define CACHE_BE_W (`CACHE_DATA_W / 8)
`define CACHE_SET_W ($clog2(`CACHE_SETS))
`define CACHE_WAY_W ($clog2(`CACHE_WAYS))
`define CACHE_OFF_W ($clog2(`CACHE_BE_W))

// Tag sits above set index and byte offset
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_SET_W - `CACHE_OFF_W)

`endif

/* design/cache_pkg.sv */
`include "cache_cfg.svh"

package cache_pkg;

    // Address split with the tag in the high bits
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic [`CACHE_SET_W-1:0] set;
        logic [`CACHE_OFF_W-1:0] off;
    } addr_fields_t;

    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] flat;
        addr_fields_t             f;
    } addr_u;

    typedef struct packed {
        addr_u                    addr;
        logic                     is_store;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic [`CACHE_BE_W-1:0]   be;
        logic [`CACHE_TID_W-1:0]  tid;
        logic                     need_rsp;
    } core_req_t;

    // rdata is meaningless for store responses
    typedef struct packed {
        logic [`CACHE_TID_W-1:0]  tid;
        logic [`CACHE_DATA_W-1:0] rdata;
    } core_rsp_t;

    typedef struct packed {
        logic [`CACHE_WAY_W-1:0]  way;
        addr_u                    addr;
        logic [`CACHE_DATA_W-1:0] data;
    } refill_t;

    typedef struct packed {
        logic [`CACHE_ADDR_W-`CACHE_OFF_W-1:0] nline;
        logic [`CACHE_TID_W-1:0]               tid;
    } miss_t;

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] data;
        logic [`CACHE_BE_W-1:0]   be;
    } wbuf_t;

    // Item held in stage 1, either a core access or a refill write
    typedef struct packed {
        logic                     is_refill;
        logic                     is_store;
        addr_u                    addr;
        logic [`CACHE_DATA_W-1:0] data;
        logic [`CACHE_BE_W-1:0]   be;
        logic [`CACHE_WAY_W-1:0]  way;
        logic [`CACHE_TID_W-1:0]  tid;
        logic                     need_rsp;
    } st1_t;

endpackage

/* design/cache_req_stage.sv */
`timescale 1ns/10ps

module cache_req_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 core_req_valid_i,
    input  cache_pkg::core_req_t core_req_i,

    input  logic                 refill_valid_i,
    input  cache_pkg::refill_t   refill_i,

    output logic                 core_req_ready_o,
    output logic                 st1_valid_o,
    output cache_pkg::st1_t      st1_o
);

    logic            st0_valid;
    cache_pkg::st1_t st0_item;

    logic            st1_valid_q;
    cache_pkg::st1_t st1_q;

    // Refill always wins and the core waits behind it
    assign core_req_ready_o = ~refill_valid_i;

    assign st0_valid = refill_valid_i | core_req_valid_i;

    // Build the stage-1 item from the granted source
    always_comb begin
        if (refill_valid_i) begin
            st0_item.is_refill = 1'b1;
            st0_item.is_store  = 1'b0;
            st0_item.addr      = refill_i.addr;
            st0_item.data      = refill_i.data;
            // full line word is written
            st0_item.be        = '1;
            st0_item.way       = refill_i.way;
            st0_item.tid       = '0;
            st0_item.need_rsp  = 1'b0;
        end else begin
            st0_item.is_refill = 1'b0;
            st0_item.is_store  = core_req_i.is_store;
            st0_item.addr      = core_req_i.addr;
            st0_item.data      = core_req_i.wdata;
            st0_item.be        = core_req_i.be;
            st0_item.way       = '0;
            st0_item.tid       = core_req_i.tid;
            st0_item.need_rsp  = core_req_i.need_rsp;
        end
    end

    // Stage-1 payload
    always_ff @(posedge clk_i) begin
        if (st0_valid) begin
            st1_q <= st0_item;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            st1_valid_q <= 1'b0;
        end else begin
            st1_valid_q <= st0_valid;
        end
    end

    assign st1_valid_o = st1_valid_q;
    assign st1_o       = st1_q;

endmodule

/* design/cache_way.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_way #(
    parameter int unsigned WAY_ID = 0
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    input  logic                     st1_valid_i,
    input  cache_pkg::st1_t          st1_i,

    output logic                     hit_o,
    output logic [`CACHE_DATA_W-1:0] rdata_o
);

    localparam int unsigned WAY_W = `CACHE_WAY_W;

    logic [`CACHE_SETS-1:0]   valid_q;
    logic [`CACHE_TAG_W-1:0]  tag_q  [`CACHE_SETS];
    logic [`CACHE_DATA_W-1:0] data_q [`CACHE_SETS];

    logic [`CACHE_SET_W-1:0]  set;
    logic [`CACHE_TAG_W-1:0]  tag;
    logic                     refill_we;
    logic                     store_we;
    logic [`CACHE_DATA_W-1:0] merged;

    assign set = st1_i.addr.f.set;
    assign tag = st1_i.addr.f.tag;

    // Lookup for core items only
    assign hit_o   = st1_valid_i & ~st1_i.is_refill & valid_q[set] & (tag_q[set] == tag);
    assign rdata_o = data_q[set];

    assign refill_we = st1_valid_i & st1_i.is_refill & (st1_i.way == WAY_W'(WAY_ID));
    assign store_we  = hit_o & st1_i.is_store;

    // Refills carry a full byte enable and overwrite the whole word
    always_comb begin
        merged = data_q[set];
        for (int b = 0; b < `CACHE_BE_W; b++) begin
            if (st1_i.be[b]) begin
                merged[8*b +: 8] = st1_i.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (refill_we) begin
            valid_q[set] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_we) begin
            tag_q[set] <= tag;
        end
        if (refill_we | store_we) begin
            data_q[set] <= merged;
        end
    end

endmodule

/* design/cache_rsp_collect.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_rsp_collect (
    input  logic                                        st1_valid_i,
    input  cache_pkg::st1_t                             st1_i,

    input  logic [`CACHE_WAYS-1:0]                      way_hit_i,
    input  logic [`CACHE_WAYS-1:0][`CACHE_DATA_W-1:0]   way_rdata_i,

    output logic                                        core_rsp_valid_o,
    output cache_pkg::core_rsp_t                        core_rsp_o,

    output logic                                        miss_valid_o,
    output cache_pkg::miss_t                            miss_o,

    output logic                                        wbuf_write_o,
    output cache_pkg::wbuf_t                            wbuf_o
);

    logic                     any_hit;
    logic [`CACHE_DATA_W-1:0] hit_data;
    logic                     is_load;
    logic                     is_store;

    // At most one way hits, so an OR of masked words picks it
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_data = hit_data | (way_rdata_i[w] & {`CACHE_DATA_W{way_hit_i[w]}});
        end
    end

    assign any_hit = |way_hit_i;

    assign is_load  = st1_valid_i & ~st1_i.is_refill & ~st1_i.is_store;
    assign is_store = st1_valid_i & ~st1_i.is_refill & st1_i.is_store;

    // Core response
    assign core_rsp_valid_o = (is_load & any_hit) | (is_store & st1_i.need_rsp);
    assign core_rsp_o.tid   = st1_i.tid;
    assign core_rsp_o.rdata = hit_data;

    // Load miss notice
    assign miss_valid_o = is_load & ~any_hit;
    assign miss_o.nline = {st1_i.addr.f.tag, st1_i.addr.f.set};
    assign miss_o.tid   = st1_i.tid;

    // Every store goes out to the write buffer whether it hit or not
    assign wbuf_write_o = is_store;
    assign wbuf_o.addr  = st1_i.addr.flat;
    assign wbuf_o.data  = st1_i.data;
    assign wbuf_o.be    = st1_i.be;

endmodule

/* design/cache_ctrl_top.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_ctrl_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    // Core request
    input  logic                 core_req_valid_i,
    input  cache_pkg::core_req_t core_req_i,
    output logic                 core_req_ready_o,

    // Refill write
    input  logic                 refill_valid_i,
    input  cache_pkg::refill_t   refill_i,

    // Core response
    output logic                 core_rsp_valid_o,
    output cache_pkg::core_rsp_t core_rsp_o,

    // Miss notice
    output logic                 miss_valid_o,
    output cache_pkg::miss_t     miss_o,

    // Write buffer
    output logic                 wbuf_write_o,
    output cache_pkg::wbuf_t     wbuf_o
);

    logic                                      st1_valid;
    cache_pkg::st1_t                           st1;
    logic [`CACHE_WAYS-1:0]                    way_hit;
    logic [`CACHE_WAYS-1:0][`CACHE_DATA_W-1:0] way_rdata;

    cache_req_stage cache_req_stage_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .core_req_i       (core_req_i),
        .refill_valid_i   (refill_valid_i),
        .refill_i         (refill_i),
        .core_req_ready_o (core_req_ready_o),
        .st1_valid_o      (st1_valid),
        .st1_o            (st1)
    );

    // All ways look up the same item in parallel
    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : gen_way
        cache_way #(
            .WAY_ID (w)
        ) cache_way_i (
            .clk_i       (clk_i),
            .rst_ni      (rst_ni),
            .st1_valid_i (st1_valid),
            .st1_i       (st1),
            .hit_o       (way_hit[w]),
            .rdata_o     (way_rdata[w])
        );
    end

    cache_rsp_collect cache_rsp_collect_i (
        .st1_valid_i      (st1_valid),
        .st1_i            (st1),
        .way_hit_i        (way_hit),
        .way_rdata_i      (way_rdata),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .miss_valid_o     (miss_valid_o),
        .miss_o           (miss_o),
        .wbuf_write_o     (wbuf_write_o),
        .wbuf_o           (wbuf_o)
    );

endmodule

/* testbench/tb_cache_ctrl.sv */
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tb_cache_ctrl;

    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 65;
    localparam int WAYS       = `CACHE_WAYS;
    localparam int SETS       = `CACHE_SETS;
    localparam int DATA_W     = `CACHE_DATA_W;
    localparam int ADDR_W     = `CACHE_ADDR_W;
    localparam int BE_W       = `CACHE_BE_W;
    localparam int TID_W      = `CACHE_TID_W;
    localparam int WAY_W      = `CACHE_WAY_W;
    localparam int SET_W      = `CACHE_SET_W;
    localparam int OFF_W      = `CACHE_OFF_W;
    localparam int TAG_W      = `CACHE_TAG_W;

    // Directed tests stay well below N_DIRECTED items
    localparam int N_RAND      = 3000;
    localparam int N_DIRECTED  = 60;
    localparam int TIMEOUT_CYC = (N_DIRECTED + N_RAND) * 4 + 200;

    localparam int KIND_NONE   = 0;
    localparam int KIND_REFILL = 1;
    localparam int KIND_CORE   = 2;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 core_req_valid_i;
    cache_pkg::core_req_t core_req_i;
    logic                 core_req_ready_o;
    logic                 refill_valid_i;
    cache_pkg::refill_t   refill_i;
    logic                 core_rsp_valid_o;
    cache_pkg::core_rsp_t core_rsp_o;
    logic                 miss_valid_o;
    cache_pkg::miss_t     miss_o;
    logic                 wbuf_write_o;
    cache_pkg::wbuf_t     wbuf_o;

    // Reference model of the ways
    logic              m_valid [WAYS][SETS];
    logic [TAG_W-1:0]  m_tag   [WAYS][SETS];
    logic [DATA_W-1:0] m_data  [WAYS][SETS];

    // Item that sits in stage 1 during the current cycle
    int                   pend_kind;
    cache_pkg::refill_t   pend_rf;
    cache_pkg::core_req_t pend_cr;

    int err_cnt;
    int check_cnt;
    int test_cnt;
    int bad_cnt;
    int test_err_base;

    cache_ctrl_top cache_ctrl_top_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .core_req_i       (core_req_i),
        .core_req_ready_o (core_req_ready_o),
        .refill_valid_i   (refill_valid_i),
        .refill_i         (refill_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .miss_valid_o     (miss_valid_o),
        .miss_o           (miss_o),
        .wbuf_write_o     (wbuf_write_o),
        .wbuf_o           (wbuf_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYC);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int off);
        return {TAG_W'(tag), SET_W'(set), OFF_W'(off)};
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        return make_addr(int'($urandom_range(3)), int'($urandom_range(3)),
                         int'($urandom_range(3)));
    endfunction

    function automatic cache_pkg::core_req_t make_req(input logic [ADDR_W-1:0] addr,
                                                      input logic is_store,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input int be, input int tid,
                                                      input logic need_rsp);
        cache_pkg::core_req_t r;
        r.addr.flat = addr;
        r.is_store  = is_store;
        r.wdata     = wdata;
        r.be        = BE_W'(be);
        r.tid       = TID_W'(tid);
        r.need_rsp  = need_rsp;
        return r;
    endfunction

    function automatic cache_pkg::core_req_t rand_req();
        return make_req(rand_addr(), 1'($urandom_range(1)), $urandom,
                        int'($urandom_range((1 << BE_W) - 1)),
                        int'($urandom_range((1 << TID_W) - 1)), 1'($urandom_range(1)));
    endfunction

    // Way index holding the line or -1 on a miss
    function automatic int find_hit(input logic [ADDR_W-1:0] a);
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[w][a[OFF_W +: SET_W]] &&
                m_tag[w][a[OFF_W +: SET_W]] == a[ADDR_W-1 -: TAG_W])
                return w;
        end
        return -1;
    endfunction

    // Line cached in the model or about to be written by the refill in stage 1
    function automatic logic line_present(input logic [ADDR_W-1:0] a);
        if (find_hit(a) >= 0)
            return 1'b1;
        return (pend_kind == KIND_REFILL) &&
               (pend_rf.addr.flat[ADDR_W-1:OFF_W] == a[ADDR_W-1:OFF_W]);
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got_v);
        check_cnt++;
        assert (got_v === exp_v) else begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, exp_v, got_v, $time);
            err_cnt++;
        end
    endtask

    // Compare the strobes of the stage-1 item, then retire it into the model
    task automatic check_stage1();
        logic              exp_rsp;
        logic              exp_miss;
        logic              exp_wb;
        logic [ADDR_W-1:0] a;
        logic [SET_W-1:0]  s;
        int                hw;
        exp_rsp  = 1'b0;
        exp_miss = 1'b0;
        exp_wb   = 1'b0;
        hw       = -1;
        a        = pend_cr.addr.flat;
        s        = a[OFF_W +: SET_W];
        if (pend_kind == KIND_CORE) begin
            hw = find_hit(a);
            if (pend_cr.is_store) begin
                exp_wb  = 1'b1;
                exp_rsp = pend_cr.need_rsp;
            end else begin
                exp_rsp  = (hw >= 0);
                exp_miss = (hw < 0);
            end
        end
        check_val("core_rsp_valid_o", 64'(exp_rsp), 64'(core_rsp_valid_o));
        check_val("miss_valid_o", 64'(exp_miss), 64'(miss_valid_o));
        check_val("wbuf_write_o", 64'(exp_wb), 64'(wbuf_write_o));
        if (exp_rsp && core_rsp_valid_o) begin
            check_val("core_rsp_o.tid", 64'(pend_cr.tid), 64'(core_rsp_o.tid));
            if (!pend_cr.is_store)
                check_val("core_rsp_o.rdata", 64'(m_data[hw][s]), 64'(core_rsp_o.rdata));
        end
        if (exp_miss && miss_valid_o) begin
            check_val("miss_o.nline", 64'(a[ADDR_W-1:OFF_W]), 64'(miss_o.nline));
            check_val("miss_o.tid", 64'(pend_cr.tid), 64'(miss_o.tid));
        end
        if (exp_wb && wbuf_write_o) begin
            check_val("wbuf_o.addr", 64'(a), 64'(wbuf_o.addr));
            check_val("wbuf_o.data", 64'(pend_cr.wdata), 64'(wbuf_o.data));
            check_val("wbuf_o.be", 64'(pend_cr.be), 64'(wbuf_o.be));
        end
        if (pend_kind == KIND_REFILL) begin
            s = pend_rf.addr.flat[OFF_W +: SET_W];
            m_valid[pend_rf.way][s] = 1'b1;
            m_tag[pend_rf.way][s]   = pend_rf.addr.flat[ADDR_W-1 -: TAG_W];
            m_data[pend_rf.way][s]  = pend_rf.data;
        end else if (pend_kind == KIND_CORE && pend_cr.is_store && hw >= 0) begin
            for (int b = 0; b < BE_W; b++) begin
                if (pend_cr.be[b])
                    m_data[hw][s][8*b +: 8] = pend_cr.wdata[8*b +: 8];
            end
        end
    endtask

    // One cycle from falling edge to falling edge
    task automatic send(input logic rf_v, input cache_pkg::refill_t rf, input logic cr_v,
                        input cache_pkg::core_req_t cr, output logic taken);
        check_stage1();
        refill_valid_i   = rf_v;
        refill_i         = rf;
        core_req_valid_i = cr_v;
        core_req_i       = cr;
        #1;
        check_val("core_req_ready_o", 64'(!rf_v), 64'(core_req_ready_o));
        taken = cr_v && !rf_v;
        @(posedge clk_i);
        if (rf_v) begin
            pend_kind = KIND_REFILL;
            pend_rf   = rf;
        end else if (cr_v) begin
            pend_kind = KIND_CORE;
            pend_cr   = cr;
        end else begin
            pend_kind = KIND_NONE;
        end
        @(negedge clk_i);
    endtask

    task automatic idle();
        logic taken;
        send(1'b0, '0, 1'b0, '0, taken);
    endtask

    task automatic finish_test(input string name);
        int errs;
        idle();
        errs = err_cnt - test_err_base;
        test_cnt++;
        if (errs == 0) begin
            $display("test %0d %-28s ok", test_cnt, name);
        end else begin
            $display("test %0d %-28s %0d errors", test_cnt, name, errs);
            bad_cnt++;
        end
        test_err_base = err_cnt;
    endtask

    initial begin
        cache_pkg::core_req_t cr;
        cache_pkg::refill_t   rf;
        logic [ADDR_W-1:0]    a;
        logic                 taken;
        logic                 held;
        logic                 rf_v;
        logic                 cr_v;
        void'($urandom(SEED));
        rst_ni           = 1'b0;
        core_req_valid_i = 1'b0;
        core_req_i       = '0;
        refill_valid_i   = 1'b0;
        refill_i         = '0;
        pend_kind        = KIND_NONE;
        pend_rf          = '0;
        pend_cr          = '0;
        err_cnt          = 0;
        check_cnt        = 0;
        test_cnt         = 0;
        bad_cnt          = 0;
        test_err_base    = 0;
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++)
                m_valid[w][s] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        for (int i = 0; i < 16; i++)
            send(1'b0, '0, 1'b1, make_req(rand_addr(), 1'b0, '0, 0, i, 1'b0), taken);
        finish_test("load miss after reset");

        // Refill immediately followed by a load of the same line
        for (int i = 0; i < 8; i++) begin
            rf.way       = WAY_W'(i % WAYS);
            rf.addr.flat = make_addr('h200 + i, i, 0);
            rf.data      = $urandom;
            send(1'b1, rf, 1'b0, '0, taken);
            a = make_addr('h200 + i, i, i % 4);
            send(1'b0, '0, 1'b1, make_req(a, 1'b0, '0, 0, i, 1'b0), taken);
        end
        finish_test("refill then load hit");

        a            = make_addr('h300, 5, 0);
        rf.way       = WAY_W'(1 % WAYS);
        rf.addr.flat = a;
        rf.data      = 32'h1122_3344;
        send(1'b1, rf, 1'b0, '0, taken);
        send(1'b0, '0, 1'b1, make_req(a, 1'b1, 32'haabb_ccdd, 'b0101, 1, 1'b0), taken);
        send(1'b0, '0, 1'b1, make_req(a, 1'b0, '0, 0, 2, 1'b0), taken);
        a = make_addr('h301, 6, 2);
        send(1'b0, '0, 1'b1, make_req(a, 1'b1, 32'h5566_7788, 'b1111, 3, 1'b0), taken);
        send(1'b0, '0, 1'b1, make_req(a, 1'b0, '0, 0, 4, 1'b0), taken);
        finish_test("store merge and store miss");

        a = make_addr('h300, 5, 1);
        send(1'b0, '0, 1'b1, make_req(a, 1'b1, 32'h0102_0304, 'b0010, 3, 1'b0), taken);
        send(1'b0, '0, 1'b1, make_req(a, 1'b1, 32'h0506_0708, 'b1000, 4, 1'b1), taken);
        a = make_addr('h302, 7, 0);
        send(1'b0, '0, 1'b1, make_req(a, 1'b1, 32'h090a_0b0c, 'b0001, 5, 1'b1), taken);
        finish_test("store response by need_rsp");

        // Core load held behind a burst of refills that includes its own line
        cr = make_req(make_addr('h311, 10, 0), 1'b0, '0, 0, 6, 1'b0);
        for (int j = 0; j < 3; j++) begin
            rf.way       = WAY_W'((j + 2) % WAYS);
            rf.addr.flat = make_addr('h311 + j, 10 + j, 0);
            rf.data      = $urandom;
            send(1'b1, rf, 1'b1, cr, taken);
        end
        taken = 1'b0;
        while (!taken)
            send(1'b0, '0, 1'b1, cr, taken);
        finish_test("ready low during refill");

        held = 1'b0;
        cr_v = 1'b0;
        cr   = '0;
        for (int i = 0; i < N_RAND; i++) begin
            if (!held) begin
                cr_v = ($urandom_range(3) != 0);
                cr   = rand_req();
            end
            rf_v = 1'b0;
            rf   = '0;
            if ($urandom_range(4) == 0) begin
                a = rand_addr();
                if (!line_present(a)) begin
                    rf_v         = 1'b1;
                    rf.way       = WAY_W'($urandom_range(WAYS - 1));
                    rf.addr.flat = a;
                    rf.data      = $urandom;
                end
            end
            send(rf_v, rf, cr_v, cr, taken);
            held = cr_v && !taken;
        end
        finish_test("random mix");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, bad_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/cache_pkg.sv
design/cache_req_stage.sv
design/cache_way.sv
design/cache_rsp_collect.sv
design/cache_ctrl_top.sv
testbench/tb_cache_ctrl.sv

/* Makefile */
# Verilator build and run of the cache controller testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_ctrl
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
